// File: src/csr_index_params.svh
// Width and depth macros for the CSR index engine, included by the package and the RTL
`ifndef CSR_INDEX_PARAMS_SVH
`define CSR_INDEX_PARAMS_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// Byte address toward memory
`define CSR_ADDR_WIDTH 32

// Response data word and engine packet value
`define CSR_DATA_WIDTH 32

// Vertex index, also used as the request tag
`define CSR_INDEX_WIDTH 16

// ------------------------------
// Flow control
// ------------------------------

// Requests in flight before the generator stalls
`define CSR_OUTSTANDING_MAX 8

`endif

// File: src/csr_index_pkg.sv
// Packed struct and enum types shared by all CSR index engine modules and the testbench
`include "csr_index_params.svh"

package csr_index_pkg;

    // ------------------------------
    // Encodings
    // ------------------------------

    // Which consumer a memory response belongs to
    typedef enum logic [0:0] {
        DEST_CONFIG    = 1'b0,
        DEST_GENERATOR = 1'b1
    } csr_dest_e;

    // Setup field carried by a config response
    typedef enum logic [1:0] {
        FIELD_INDEX_START   = 2'd0,
        FIELD_INDEX_END     = 2'd1,
        FIELD_ARRAY_POINTER = 2'd2,
        FIELD_ARRAY_STRIDE  = 2'd3
    } csr_field_e;

    // ------------------------------
    // Stream payloads
    // ------------------------------

    // Field only matters for config beats, tag only for generator beats
    typedef struct packed {
        csr_dest_e                   dest;
        csr_field_e                  field;
        logic [`CSR_INDEX_WIDTH-1:0] tag;
        logic [`CSR_DATA_WIDTH-1:0]  data;
    } memory_response_t;

    // Read request, tagged with the vertex index
    typedef struct packed {
        logic [`CSR_ADDR_WIDTH-1:0]  address;
        logic [`CSR_INDEX_WIDTH-1:0] tag;
    } memory_request_t;

    // Result handed to the next engine
    typedef struct packed {
        logic [`CSR_INDEX_WIDTH-1:0] vertex_index;
        logic [`CSR_DATA_WIDTH-1:0]  value;
    } engine_packet_t;

    // Setup of one run, range is half open
    typedef struct packed {
        logic [`CSR_INDEX_WIDTH-1:0] index_start;
        logic [`CSR_INDEX_WIDTH-1:0] index_end;
        logic [`CSR_ADDR_WIDTH-1:0]  array_pointer;
        logic [`CSR_DATA_WIDTH-1:0]  array_stride;
    } csr_config_t;

endpackage

// File: src/stream_register.sv
// Registered valid/ready stage with a one-beat skid slot, instantiated per stream payload type
`timescale 1ns/10ps

module stream_register #(
    parameter type payload_t = logic
) (
    input  logic     ap_clk,
    input  logic     areset_csr_engine,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    logic     skid_valid;
    payload_t skid_payload;
    logic     main_free;

    // Main slot can take a beat this cycle
    assign main_free = out_ready || !out_valid;

    // Ready only from local state, so the path is cut here
    assign in_ready = !skid_valid;

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // Drain skid first, else take the input directly
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_valid;
            end
        end else if (in_valid && in_ready) begin
            // Output stalled, park the beat
            skid_valid <= 1'b1;
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (main_free) begin
            out_payload <= skid_valid ? skid_payload : in_payload;
        end
        // Only meaningful when skid_valid gets set
        if (in_ready) begin
            skid_payload <= in_payload;
        end
    end

endmodule

// File: src/csr_config_loader.sv
// Steers memory responses by destination, loads the run setup and forwards data beats on
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_config_loader (
    input  logic                          ap_clk,
    input  logic                          areset_csr_engine,
    input  logic                          response_valid,
    output logic                          response_ready,
    input  csr_index_pkg::memory_response_t response,
    output logic                          data_valid,
    input  logic                          data_ready,
    output csr_index_pkg::memory_response_t data,
    output csr_index_pkg::csr_config_t    csr_config,
    output logic                          config_valid
);

    logic       config_accept;
    logic [3:0] seen_mask;
    logic [3:0] seen_next;

    // ------------------------------
    // Routing
    // ------------------------------

    // Generator beats go straight through
    assign data_valid = response_valid && (response.dest == csr_index_pkg::DEST_GENERATOR);
    assign data       = response;

    // Config beats are always taken
    assign response_ready = (response.dest == csr_index_pkg::DEST_CONFIG) ? 1'b1 : data_ready;
    assign config_accept  = response_valid && (response.dest == csr_index_pkg::DEST_CONFIG);

    // Mask including the beat now arriving
    assign seen_next = seen_mask | (4'b0001 << response.field);

    // ------------------------------
    // Field tracking
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            seen_mask    <= 4'b0000;
            config_valid <= 1'b0;
        end else if (config_accept) begin
            seen_mask <= seen_next;
            // Sticky once all four fields are in
            if (&seen_next) begin
                config_valid <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Field registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (config_accept) begin
            // Repeats simply overwrite, last one wins
            case (response.field)
                csr_index_pkg::FIELD_INDEX_START:
                    csr_config.index_start <= response.data[`CSR_INDEX_WIDTH-1:0];
                csr_index_pkg::FIELD_INDEX_END:
                    csr_config.index_end <= response.data[`CSR_INDEX_WIDTH-1:0];
                csr_index_pkg::FIELD_ARRAY_POINTER:
                    csr_config.array_pointer <= response.data[`CSR_ADDR_WIDTH-1:0];
                default:
                    csr_config.array_stride <= response.data;
            endcase
        end
    end

endmodule

// File: src/csr_request_generator.sv
// Walks the configured vertex range and issues one tagged memory read per index
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_request_generator (
    input  logic                         ap_clk,
    input  logic                         areset_csr_engine,
    input  csr_index_pkg::csr_config_t   csr_config,
    input  logic                         config_valid,
    input  logic                         collector_full,
    output logic                         request_valid,
    input  logic                         request_ready,
    output csr_index_pkg::memory_request_t request,
    output logic                         issue_pulse
);

    logic                        started;
    logic                        running;
    logic                        start_run;
    logic                        request_accept;
    logic [`CSR_INDEX_WIDTH-1:0] current_index;
    logic [`CSR_INDEX_WIDTH-1:0] next_index;
    logic [`CSR_ADDR_WIDTH-1:0]  current_address;

    // One-time load on the first cycle of config_valid
    assign start_run = config_valid && !started;

    // ------------------------------
    // Request stream
    // ------------------------------

    // Stall while the collector has too many in flight
    assign request_valid   = running && !collector_full;
    assign request_accept  = request_valid && request_ready;
    assign issue_pulse     = request_accept;
    assign request.address = current_address;
    assign request.tag     = current_index;
    assign next_index      = current_index + 1'b1;

    // ------------------------------
    // Index walk
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            started       <= 1'b0;
            running       <= 1'b0;
            current_index <= '0;
        end else if (start_run) begin
            started       <= 1'b1;
            // Empty or inverted range never runs
            running       <= (csr_config.index_start < csr_config.index_end);
            current_index <= csr_config.index_start;
        end else if (request_accept) begin
            current_index <= next_index;
            // Last index issued, stop until reset
            if (next_index == csr_config.index_end) begin
                running <= 1'b0;
            end
        end
    end

    // Running address, pointer plus offset times stride
    always_ff @(posedge ap_clk) begin
        if (start_run) begin
            current_address <= csr_config.array_pointer;
        end else if (request_accept) begin
            current_address <= current_address + csr_config.array_stride[`CSR_ADDR_WIDTH-1:0];
        end
    end

endmodule

// File: src/csr_index_collector.sv
// Turns data responses into engine packets, tracks requests in flight and flags run completion
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_index_collector (
    input  logic                          ap_clk,
    input  logic                          areset_csr_engine,
    input  csr_index_pkg::csr_config_t    csr_config,
    input  logic                          config_valid,
    input  logic                          issue_pulse,
    input  logic                          data_valid,
    output logic                          data_ready,
    input  csr_index_pkg::memory_response_t data,
    output logic                          packet_valid,
    input  logic                          packet_ready,
    output csr_index_pkg::engine_packet_t packet,
    output logic                          collector_full,
    output logic                          done
);

    localparam int OUTSTANDING_WIDTH = $clog2(`CSR_OUTSTANDING_MAX + 1);

    logic [OUTSTANDING_WIDTH-1:0] outstanding;
    logic [`CSR_INDEX_WIDTH-1:0]  returned_count;
    logic [`CSR_INDEX_WIDTH-1:0]  returned_next;
    logic [`CSR_INDEX_WIDTH-1:0]  expected_count;
    logic                         packet_accept;
    logic                         empty_range;

    // ------------------------------
    // Packet mapping
    // ------------------------------

    // Tag is the vertex index, data the value read
    assign packet_valid        = data_valid;
    assign data_ready          = packet_ready;
    assign packet.vertex_index = data.tag;
    assign packet.value        = data.data;
    assign packet_accept       = packet_valid && packet_ready;

    // ------------------------------
    // Outstanding requests
    // ------------------------------
    assign collector_full = (outstanding == OUTSTANDING_WIDTH'(`CSR_OUTSTANDING_MAX));

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            outstanding <= '0;
        end else begin
            // Issue and return in the same cycle cancel out
            case ({issue_pulse, packet_accept})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // ------------------------------
    // Completion
    // ------------------------------
    assign expected_count = csr_config.index_end - csr_config.index_start;
    assign empty_range    = (csr_config.index_end <= csr_config.index_start);
    assign returned_next  = returned_count + 1'b1;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            returned_count <= '0;
            done           <= 1'b0;
        end else begin
            if (packet_accept) begin
                returned_count <= returned_next;
            end
            // Nothing to fetch, or last response just went out
            if (config_valid && (empty_range ||
                (packet_accept && (returned_next == expected_count)))) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// File: src/csr_index_engine.sv
// Top level of the CSR index engine, chaining input stage, config, generator and collector
`timescale 1ns/10ps

module csr_index_engine (
    input  logic                          ap_clk,
    input  logic                          areset_csr_engine,
    input  logic                          memory_response_valid,
    output logic                          memory_response_ready,
    input  csr_index_pkg::memory_response_t memory_response,
    output logic                          memory_request_valid,
    input  logic                          memory_request_ready,
    output csr_index_pkg::memory_request_t  memory_request,
    output logic                          engine_packet_valid,
    input  logic                          engine_packet_ready,
    output csr_index_pkg::engine_packet_t   engine_packet,
    output logic                          done
);

    // ------------------------------
    // Internal streams
    // ------------------------------

    // Registered response into the loader
    logic                            response_valid;
    logic                            response_ready;
    csr_index_pkg::memory_response_t response;

    // Generator beats toward the collector
    logic                            data_valid;
    logic                            data_ready;
    csr_index_pkg::memory_response_t data;

    csr_index_pkg::csr_config_t      csr_config;
    logic                            config_valid;

    // Generator to output stage
    logic                            request_valid;
    logic                            request_ready;
    csr_index_pkg::memory_request_t  request;
    logic                            issue_pulse;
    logic                            collector_full;

    // Collector to output stage
    logic                            packet_valid;
    logic                            packet_ready;
    csr_index_pkg::engine_packet_t   packet;
    logic                            collector_done;

    // Done only once the last packet has left the output stage
    assign done = collector_done && !engine_packet_valid;

    // ------------------------------
    // Input stage
    // ------------------------------
    stream_register #(
        .payload_t(csr_index_pkg::memory_response_t)
    ) response_stage (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .in_valid          (memory_response_valid),
        .in_ready          (memory_response_ready),
        .in_payload        (memory_response),
        .out_valid         (response_valid),
        .out_ready         (response_ready),
        .out_payload       (response)
    );

    csr_config_loader config_loader (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .response_valid    (response_valid),
        .response_ready    (response_ready),
        .response          (response),
        .data_valid        (data_valid),
        .data_ready        (data_ready),
        .data              (data),
        .csr_config        (csr_config),
        .config_valid      (config_valid)
    );

    // ------------------------------
    // Request path
    // ------------------------------
    csr_request_generator request_generator (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .csr_config        (csr_config),
        .config_valid      (config_valid),
        .collector_full    (collector_full),
        .request_valid     (request_valid),
        .request_ready     (request_ready),
        .request           (request),
        .issue_pulse       (issue_pulse)
    );

    stream_register #(
        .payload_t(csr_index_pkg::memory_request_t)
    ) request_stage (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .in_valid          (request_valid),
        .in_ready          (request_ready),
        .in_payload        (request),
        .out_valid         (memory_request_valid),
        .out_ready         (memory_request_ready),
        .out_payload       (memory_request)
    );

    // ------------------------------
    // Response path
    // ------------------------------
    csr_index_collector index_collector (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .csr_config        (csr_config),
        .config_valid      (config_valid),
        .issue_pulse       (issue_pulse),
        .data_valid        (data_valid),
        .data_ready        (data_ready),
        .data              (data),
        .packet_valid      (packet_valid),
        .packet_ready      (packet_ready),
        .packet            (packet),
        .collector_full    (collector_full),
        .done              (collector_done)
    );

    stream_register #(
        .payload_t(csr_index_pkg::engine_packet_t)
    ) packet_stage (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .in_valid          (packet_valid),
        .in_ready          (packet_ready),
        .in_payload        (packet),
        .out_valid         (engine_packet_valid),
        .out_ready         (engine_packet_ready),
        .out_payload       (engine_packet)
    );

endmodule

// File: verification/csr_index_engine_assert.sv
// Stream handshake and done protocol checks, bound into the CSR index engine top level
`timescale 1ns/10ps

module csr_index_engine_assert (
    input logic                            ap_clk,
    input logic                            areset_csr_engine,
    input logic                            memory_response_valid,
    input logic                            memory_response_ready,
    input csr_index_pkg::memory_response_t memory_response,
    input logic                            memory_request_valid,
    input logic                            memory_request_ready,
    input csr_index_pkg::memory_request_t  memory_request,
    input logic                            engine_packet_valid,
    input logic                            engine_packet_ready,
    input csr_index_pkg::engine_packet_t   engine_packet,
    input logic                            done
);

    // ------------------------------
    // Hold until ready
    // ------------------------------
    request_hold: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        memory_request_valid && !memory_request_ready
        |=> memory_request_valid && $stable(memory_request))
        else $error("memory_request dropped or changed while stalled");

    packet_hold: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        engine_packet_valid && !engine_packet_ready
        |=> engine_packet_valid && $stable(engine_packet))
        else $error("engine_packet dropped or changed while stalled");

    // Input side, driven by the memory model
    response_hold: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        memory_response_valid && !memory_response_ready
        |=> memory_response_valid && $stable(memory_response))
        else $error("memory_response dropped or changed while stalled");

    // Done never falls before reset
    done_sticky: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        done |=> done)
        else $error("done fell without a reset");

    reset_clear: assert property (@(posedge ap_clk)
        areset_csr_engine |=> !memory_request_valid && !engine_packet_valid && !done)
        else $error("Outputs not cleared by reset");

endmodule

bind csr_index_engine csr_index_engine_assert protocol_checks (.*);

// File: verification/csr_index_engine_tb.sv
// Self-checking testbench for the CSR index engine: random runs, memory model and scoreboard
`timescale 1ns/10ps
`include "csr_index_params.svh"

module csr_index_engine_tb;

    localparam int RUN_COUNT      = 6;
    localparam int MAX_LENGTH     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = RUN_COUNT * (MAX_LENGTH * 30 + 300);

    logic                            ap_clk;
    logic                            areset_csr_engine;
    logic                            memory_response_valid;
    logic                            memory_response_ready;
    csr_index_pkg::memory_response_t memory_response;
    logic                            memory_request_valid;
    logic                            memory_request_ready;
    csr_index_pkg::memory_request_t  memory_request;
    logic                            engine_packet_valid;
    logic                            engine_packet_ready;
    csr_index_pkg::engine_packet_t   engine_packet;
    logic                            done;

    // ------------------------------
    // Reference state of one run
    // ------------------------------
    csr_index_pkg::csr_config_t      run_config;
    int                              run_length;
    int                              requests_seen;
    int                              packets_seen;
    int                              config_beats_total;
    int                              config_beats_accepted;
    logic                            done_seen;

    // Memory model, pending reads and the word returned per tag
    csr_index_pkg::memory_response_t response_queue[$];
    logic [`CSR_INDEX_WIDTH-1:0]     pending_tags[$];
    logic [`CSR_DATA_WIDTH-1:0]      data_by_tag[int];
    bit                              packet_tag_seen[int];

    csr_index_engine dut (.*);

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // ------------------------------
    // Failure reporting and compares
    // ------------------------------
    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic check_request(input csr_index_pkg::memory_request_t got,
                                 input csr_index_pkg::memory_request_t expected);
        if (got !== expected) begin
            stop_on_failure($sformatf("Mismatch at %0t: memory_request expected %h/%h got %h/%h",
                $time, expected.address, expected.tag, got.address, got.tag));
        end
    endtask

    task automatic check_packet(input csr_index_pkg::engine_packet_t got,
                                input csr_index_pkg::engine_packet_t expected);
        if (got !== expected) begin
            stop_on_failure($sformatf("Mismatch at %0t: engine_packet expected %h/%h got %h/%h",
                $time, expected.vertex_index, expected.value, got.vertex_index, got.value));
        end
    endtask

    task automatic check_done(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            stop_on_failure($sformatf("Mismatch at %0t: %s expected %b got %b",
                $time, name, expected, got));
        end
    endtask

    // One config beat into the response stream
    task automatic queue_config_beat(input logic [1:0] field, input logic [31:0] value);
        csr_index_pkg::memory_response_t beat;
        beat.dest  = csr_index_pkg::DEST_CONFIG;
        beat.field = csr_index_pkg::csr_field_e'(field);
        beat.tag   = '0;
        beat.data  = value;
        response_queue.push_back(beat);
        config_beats_total++;
    endtask

    // ------------------------------
    // Memory model and ready drivers
    // ------------------------------
    always @(posedge ap_clk) begin
        csr_index_pkg::memory_response_t beat;
        csr_index_pkg::memory_request_t  expected_request;
        int                              pick;
        // Ready low about 30 percent of the time
        memory_request_ready <= ($urandom_range(9, 0) >= 3);
        engine_packet_ready  <= ($urandom_range(9, 0) >= 3);
        if (areset_csr_engine) begin
            memory_response_valid <= 1'b0;
        end else begin
            if (memory_response_valid && memory_response_ready &&
                memory_response.dest == csr_index_pkg::DEST_CONFIG) begin
                config_beats_accepted++;
            end
            // Requests must come in index order, each once
            if (memory_request_valid && memory_request_ready) begin
                if (config_beats_accepted != config_beats_total) begin
                    stop_on_failure("Memory request issued before the configuration was loaded");
                end
                if (requests_seen >= run_length) begin
                    stop_on_failure($sformatf("Extra memory request, only %0d expected",
                        run_length));
                end
                expected_request.address = run_config.array_pointer +
                    32'(requests_seen) * run_config.array_stride;
                expected_request.tag     = run_config.index_start + 16'(requests_seen);
                check_request(memory_request, expected_request);
                requests_seen++;
                data_by_tag[int'(memory_request.tag)] = $urandom;
                pending_tags.push_back(memory_request.tag);
            end
            // Now and then answer any pending read, so order is shuffled
            if (pending_tags.size() > 0 && $urandom_range(3, 0) == 0) begin
                pick       = $urandom_range(pending_tags.size() - 1, 0);
                beat.dest  = csr_index_pkg::DEST_GENERATOR;
                beat.field = csr_index_pkg::FIELD_INDEX_START;
                beat.tag   = pending_tags[pick];
                beat.data  = data_by_tag[int'(pending_tags[pick])];
                response_queue.push_back(beat);
                pending_tags.delete(pick);
            end
            // Next beat only after the current one is taken
            if (!memory_response_valid || memory_response_ready) begin
                if (response_queue.size() > 0) begin
                    memory_response       <= response_queue.pop_front();
                    memory_response_valid <= 1'b1;
                end else begin
                    memory_response_valid <= 1'b0;
                end
            end
        end
    end

    // ------------------------------
    // Packet and done monitor
    // ------------------------------
    always @(posedge ap_clk) begin
        csr_index_pkg::engine_packet_t expected_packet;
        int                            tag;
        if (!areset_csr_engine) begin
            // Done only after the last packet, then sticky
            if (done_seen) begin
                check_done("done", done, 1'b1);
            end else if (packets_seen < run_length) begin
                check_done("done", done, 1'b0);
            end
            if (done) begin
                done_seen = 1'b1;
            end
            if (engine_packet_valid && engine_packet_ready) begin
                tag = int'(engine_packet.vertex_index);
                if (!data_by_tag.exists(tag)) begin
                    stop_on_failure($sformatf("Engine packet for tag %h never requested", tag));
                end
                if (packet_tag_seen.exists(tag)) begin
                    stop_on_failure($sformatf("Engine packet for tag %h sent twice", tag));
                end
                expected_packet.vertex_index = engine_packet.vertex_index;
                expected_packet.value        = data_by_tag[tag];
                check_packet(engine_packet, expected_packet);
                packet_tag_seen[tag] = 1'b1;
                packets_seen++;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge ap_clk);
        stop_on_failure($sformatf("Timeout, runs not finished after %0d cycles",
            TIMEOUT_CYCLES));
    end

    // ------------------------------
    // Run sequence
    // ------------------------------
    initial begin
        logic [1:0]                 order[4];
        logic [1:0]                 swap_value;
        logic [`CSR_DATA_WIDTH-1:0] field_value[4];
        int                         swap_index;
        int                         repeat_position;
        void'($urandom(32'h6d6e));
        areset_csr_engine     = 1'b1;
        memory_response_valid = 1'b0;
        memory_response       = '0;
        memory_request_ready  = 1'b0;
        engine_packet_ready   = 1'b0;
        run_config            = '0;
        run_length            = 0;
        done_seen             = 1'b0;
        for (int run = 0; run < RUN_COUNT; run++) begin
            areset_csr_engine <= 1'b1;
            @(posedge ap_clk);
            // Monitors are idle during reset
            requests_seen         = 0;
            packets_seen          = 0;
            config_beats_total    = 0;
            config_beats_accepted = 0;
            done_seen             = 1'b0;
            response_queue.delete();
            pending_tags.delete();
            data_by_tag.delete();
            packet_tag_seen.delete();
            run_length               = $urandom_range(MAX_LENGTH, 0);
            run_config.index_start   = 16'($urandom_range(65535 - MAX_LENGTH, 0));
            run_config.index_end     = run_config.index_start + 16'(run_length);
            run_config.array_pointer = $urandom;
            run_config.array_stride  = 32'($urandom_range(16, 1));
            field_value[0] = 32'(run_config.index_start);
            field_value[1] = 32'(run_config.index_end);
            field_value[2] = run_config.array_pointer;
            field_value[3] = run_config.array_stride;
            // Shuffle the field order
            for (int i = 0; i < 4; i++) begin
                order[i] = 2'(i);
            end
            for (int i = 3; i > 0; i--) begin
                swap_index        = $urandom_range(i, 0);
                swap_value        = order[i];
                order[i]          = order[swap_index];
                order[swap_index] = swap_value;
            end
            // Stale value first, overwritten before the fourth field
            repeat_position = ($urandom_range(1, 0) == 1) ? $urandom_range(2, 0) : -1;
            for (int i = 0; i < 4; i++) begin
                if (i == repeat_position) begin
                    queue_config_beat(order[i], $urandom);
                end
                queue_config_beat(order[i], field_value[order[i]]);
            end
            repeat (RESET_CYCLES - 1) @(posedge ap_clk);
            check_done("done", done, 1'b0);
            check_done("memory_request_valid", memory_request_valid, 1'b0);
            check_done("engine_packet_valid", engine_packet_valid, 1'b0);
            areset_csr_engine <= 1'b0;
            while (done !== 1'b1) @(posedge ap_clk);
            // Quiet stretch to catch late extra beats
            repeat (20) @(posedge ap_clk);
            if (requests_seen != run_length || packets_seen != run_length) begin
                stop_on_failure($sformatf("Run %0d saw %0d requests and %0d packets, %0d expected",
                    run, requests_seen, packets_seen, run_length));
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: files.f
+incdir+src
src/csr_index_pkg.sv
src/stream_register.sv
src/csr_config_loader.sv
src/csr_request_generator.sv
src/csr_index_collector.sv
src/csr_index_engine.sv
verification/csr_index_engine_assert.sv
verification/csr_index_engine_tb.sv

// File: run_verilator.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module csr_index_engine_tb -Mdir obj_dir &&
./obj_dir/Vcsr_index_engine_tb ||
exit 1
